// ==== fabric_pkg.sv ====
/* fabric control shared constants */

package fabric_pkg;

    // =========================================================================
    // board widths
    // =========================================================================
    localparam int key_width       = 4;    // push keys KEY[3:0]
    localparam int sw_width        = 10;   // slide switches
    localparam int led_width       = 10;   // red leds LEDR[9:0]
    localparam int reset_req_width = 3;    // cold warm debug request levels
    localparam int hw_event_width  = 28;   // trace hw event word into the hps

    // led control bits that land in the event word
    localparam int led_event_width = led_width - 1;   // bits 8..0 only

    // zero fill on top of the event word
    // sw + led[8:0] + keys is 23 bits so the fill is 5 wide
    // and bits 27..24 are always zero
    localparam int event_pad_width = hw_event_width - sw_width
                                     - led_event_width - key_width;

    // =========================================================================
    // timing at 50 MHz
    // =========================================================================
    localparam int debounce_cycles   = 50000;      // 1 ms of stable key
    localparam int blink_half_period = 25000000;   // 0.5 s per led level

    // reset request pulse lengths in fpga_clk_50 cycles
    localparam int cold_pulse_len  = 6;
    localparam int warm_pulse_len  = 2;
    localparam int debug_pulse_len = 32;

    // bit positions of the request levels
    localparam int req_cold_bit  = 0;
    localparam int req_warm_bit  = 1;
    localparam int req_debug_bit = 2;

endpackage

// ==== key_debounce.sv ====
/* push key synchronizer and debouncer */

`timescale 1ns/1ns

module key_debounce #(
    parameter int STABLE_CYCLES = fabric_pkg::debounce_cycles   // cycles of stable input
) (
    input  logic                            fpga_clk_50,
    input  logic                            hps_fpga_reset_n,
    input  logic [fabric_pkg::key_width-1:0] key,              // raw pins, active low
    output logic [fabric_pkg::key_width-1:0] keys_debounced    // same polarity as pins
);

    import fabric_pkg::*;

    // counter only has to reach STABLE_CYCLES-1
    localparam int cnt_w = $clog2(STABLE_CYCLES + 1);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(STABLE_CYCLES - 1);

    logic [key_width-1:0] key_meta;                 // first sync stage
    logic [key_width-1:0] key_sync;                 // second sync stage
    logic [cnt_w-1:0]     stable_cnt [key_width];   // per key run length

    // =========================================================================
    // two flop synchronizer
    // =========================================================================
    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            key_meta <= '1;          // released
            key_sync <= '1;
        end
        else
        begin
            key_meta <= key;         // async pins in
            key_sync <= key_meta;
        end
    end

    // =========================================================================
    // stability counters
    // =========================================================================
    // each key counts how long the synced level has disagreed with the
    // debounced output and takes the new level once the run is long enough
    generate
        for (genvar k = 0; k < key_width; k++)
        begin : g_key
            always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
            begin
                if (!hps_fpga_reset_n)
                begin
                    stable_cnt[k]     <= '0;
                    keys_debounced[k] <= 1'b1;          // all keys released
                end
                else if (key_sync[k] == keys_debounced[k])
                begin
                    stable_cnt[k] <= '0;                // bounce back restarts
                end
                else if (stable_cnt[k] == cnt_last)
                begin
                    stable_cnt[k]     <= '0;
                    keys_debounced[k] <= key_sync[k];   // accept new level
                end
                else
                begin
                    stable_cnt[k] <= stable_cnt[k] + cnt_w'(1);
                end
            end
        end
    endgenerate

    // worst case from pin to output is two sync cycles plus STABLE_CYCLES
    // and the output change itself marks the end of the bounce window

endmodule

// ==== reset_pulse_gen.sv ====
/* reset request edge to pulse */

`timescale 1ns/1ns

module reset_pulse_gen #(
    parameter int PULSE_LEN = fabric_pkg::cold_pulse_len   // pulse width in cycles
) (
    input  logic fpga_clk_50,
    input  logic hps_fpga_reset_n,
    input  logic req,              // request level
    output logic pulse             // active high reset pulse
);

    localparam int cnt_w = $clog2(PULSE_LEN + 1);
    localparam logic [cnt_w-1:0] cnt_load = cnt_w'(PULSE_LEN);

    logic             req_q;       // sampled request
    logic             req_prev;    // previous sample
    logic             rise_q;      // registered rising edge
    logic [cnt_w-1:0] pulse_cnt;   // cycles left in the pulse
    logic             cnt_idle;

    assign cnt_idle = (pulse_cnt == '0);

    // =========================================================================
    // edge detect
    // =========================================================================
    // req sampled high at edge n gives rise_q at n+1
    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            req_q    <= 1'b0;
            req_prev <= 1'b0;
            rise_q   <= 1'b0;
        end
        else
        begin
            req_q    <= req;
            req_prev <= req_q;
            rise_q   <= req_q & ~req_prev;   // low to high seen
        end
    end

    // =========================================================================
    // pulse stretcher
    // =========================================================================
    // loads at n+2 so the pulse starts on the second edge after sampling
    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            pulse_cnt <= '0;
        end
        else if (rise_q && cnt_idle)
        begin
            pulse_cnt <= cnt_load;                   // start new pulse
        end
        else if (!cnt_idle)
        begin
            pulse_cnt <= pulse_cnt - cnt_w'(1);      // edges here are dropped
        end
    end

    // high for exactly PULSE_LEN cycles
    assign pulse = ~cnt_idle;

endmodule

// ==== heartbeat_blinker.sv ====
/* heartbeat led blinker */

`timescale 1ns/1ns

module heartbeat_blinker #(
    parameter int HALF_PERIOD = fabric_pkg::blink_half_period   // cycles per level
) (
    input  logic fpga_clk_50,
    input  logic hps_fpga_reset_n,
    output logic blink              // heartbeat level
);

    localparam int cnt_w = $clog2(HALF_PERIOD + 1);
    localparam logic [cnt_w-1:0] cnt_wrap = cnt_w'(HALF_PERIOD - 1);

    logic [cnt_w-1:0] blink_cnt;    // free running cycle count

    // =========================================================================
    // half period counter
    // =========================================================================
    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            blink_cnt <= '0;
            blink     <= 1'b0;                    // led off out of reset
        end
        else if (blink_cnt == cnt_wrap)
        begin
            blink_cnt <= '0;                      // wrap
            blink     <= ~blink;                  // toggle every half period
        end
        else
        begin
            blink_cnt <= blink_cnt + cnt_w'(1);
        end
    end

    // full blink period is 2 * HALF_PERIOD

endmodule

// ==== fabric_control.sv ====
/* fabric side control top level */

`timescale 1ns/1ns

module fabric_control #(
    parameter int debounce_len = fabric_pkg::debounce_cycles,    // key stable cycles
    parameter int blink_half   = fabric_pkg::blink_half_period   // heartbeat half period
) (
    input  logic                                  fpga_clk_50,
    input  logic                                  hps_fpga_reset_n,
    input  logic [fabric_pkg::key_width-1:0]       key,          // push keys, active low
    input  logic [fabric_pkg::sw_width-1:0]        sw,
    input  logic [fabric_pkg::led_width-1:0]       led_ctrl,     // led bits from the hps
    input  logic [fabric_pkg::reset_req_width-1:0] reset_req,    // cold warm debug levels
    output logic [fabric_pkg::led_width-1:0]       ledr,
    output logic [fabric_pkg::key_width-1:0]       keys_debounced,
    output logic [fabric_pkg::hw_event_width-1:0]  hw_events,    // trace event word
    output logic                                  cold_reset,
    output logic                                  warm_reset,
    output logic                                  debug_reset
);

    import fabric_pkg::*;

    logic heartbeat;    // blinker level

    // =========================================================================
    // key debounce
    // =========================================================================
    key_debounce #(
        .STABLE_CYCLES (debounce_len)
    ) i_key_debounce (
        .fpga_clk_50      (fpga_clk_50),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .key              (key),
        .keys_debounced   (keys_debounced)
    );

    // =========================================================================
    // hps reset request pulses
    // =========================================================================
    reset_pulse_gen #(
        .PULSE_LEN (cold_pulse_len)
    ) i_cold_pulse (
        .fpga_clk_50      (fpga_clk_50),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .req              (reset_req[req_cold_bit]),
        .pulse            (cold_reset)
    );

    reset_pulse_gen #(
        .PULSE_LEN (warm_pulse_len)
    ) i_warm_pulse (
        .fpga_clk_50      (fpga_clk_50),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .req              (reset_req[req_warm_bit]),
        .pulse            (warm_reset)
    );

    reset_pulse_gen #(
        .PULSE_LEN (debug_pulse_len)
    ) i_debug_pulse (
        .fpga_clk_50      (fpga_clk_50),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .req              (reset_req[req_debug_bit]),
        .pulse            (debug_reset)
    );

    // heartbeat on led 0
    heartbeat_blinker #(
        .HALF_PERIOD (blink_half)
    ) i_heartbeat_blinker (
        .fpga_clk_50      (fpga_clk_50),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .blink            (heartbeat)
    );

    // =========================================================================
    // led and trace event outputs
    // =========================================================================
    assign ledr = {led_ctrl[led_width-1:1], led_ctrl[0] | heartbeat};   // hps can force led 0

    // zeros, sw, led_ctrl[8:0], keys from msb down
    assign hw_events = {{event_pad_width{1'b0}}, sw,
                        led_ctrl[led_event_width-1:0], keys_debounced};

endmodule

// ==== fabric_control_assertions.sv ====
/* fabric control assertions */

`timescale 1ns/1ns

module fabric_control_assertions (
    input logic                                  fpga_clk_50,
    input logic                                  hps_fpga_reset_n,
    input logic [fabric_pkg::led_width-1:0]      led_ctrl,
    input logic [fabric_pkg::led_width-1:0]      ledr,
    input logic [fabric_pkg::hw_event_width-1:0] hw_events,
    input logic                                  cold_reset,
    input logic                                  warm_reset,
    input logic                                  debug_reset
);

    import fabric_pkg::*;

    logic [5:0] cold_run;    // consecutive high samples
    logic [5:0] warm_run;
    logic [5:0] debug_run;

    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            cold_run  <= '0;
            warm_run  <= '0;
            debug_run <= '0;
        end
        else
        begin
            cold_run  <= cold_reset  ? cold_run + 6'd1  : '0;   // restart when low
            warm_run  <= warm_reset  ? warm_run + 6'd1  : '0;
            debug_run <= debug_reset ? debug_run + 6'd1 : '0;
        end
    end

    // =========================================================================
    // output properties
    // =========================================================================
    a_event_pad : assert property (@(posedge fpga_clk_50)
        hw_events[hw_event_width-1 -: 4] == 4'h0)
        else $error("hw_events top nibble is not zero");

    a_led0_forced : assert property (@(posedge fpga_clk_50)
        led_ctrl[0] |-> ledr[0])
        else $error("ledr[0] low while led_ctrl[0] is high");

    // run length seen on the falling sample is the whole pulse
    a_cold_len : assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
        $fell(cold_reset) |-> cold_run == 6'(cold_pulse_len))
        else $error("cold_reset pulse has the wrong length");

    a_warm_len : assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
        $fell(warm_reset) |-> warm_run == 6'(warm_pulse_len))
        else $error("warm_reset pulse has the wrong length");

    a_debug_len : assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
        $fell(debug_reset) |-> debug_run == 6'(debug_pulse_len))
        else $error("debug_reset pulse has the wrong length");

endmodule

bind fabric_control fabric_control_assertions i_fabric_control_assertions (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .led_ctrl         (led_ctrl),
    .ledr             (ledr),
    .hw_events        (hw_events),
    .cold_reset       (cold_reset),
    .warm_reset       (warm_reset),
    .debug_reset      (debug_reset)
);

// ==== tb_fabric_control.sv ====
/* fabric control testbench */

`timescale 1ns/1ns

module tb_fabric_control;

    import fabric_pkg::*;

    localparam int debounce_len  = 8;
    localparam int blink_half    = 40;
    localparam int reset_cycles  = 10;
    localparam int margin_cycles = 40;    // slack on top of the table
    localparam int num_steps     = 17;
    localparam int pulse_len [reset_req_width] = '{cold_pulse_len, warm_pulse_len,
                                                   debug_pulse_len};

    typedef struct packed {
        bit                         bounce;     // short glitches toward key
        logic [key_width-1:0]       key;
        int                         hold;       // cycles in this row
        logic [reset_req_width-1:0] req;
        logic [sw_width-1:0]        sw;
        logic [led_width-1:0]       led;
        logic [key_width-1:0]       exp_keys;   // keys_debounced at row end
    } step_t;

    // bounce, key, hold, reset_req, sw, led_ctrl, expected keys
    step_t steps [num_steps] = '{
        '{1'b0, 4'hF,  6, 3'b000, 10'h000, 10'h000, 4'hF},   // idle
        '{1'b0, 4'hE, 12, 3'b000, 10'h155, 10'h0AA, 4'hE},   // key 0 pressed
        '{1'b1, 4'hF, 20, 3'b000, 10'h2AA, 10'h154, 4'hE},   // release bounces
        '{1'b0, 4'hF,  2, 3'b001, 10'h3C3, 10'h0F0, 4'hE},   // cold edge
        '{1'b0, 4'hF,  1, 3'b000, 10'h3C3, 10'h0F0, 4'hE},
        '{1'b0, 4'hF, 12, 3'b001, 10'h0FF, 10'h300, 4'hF},   // edge inside pulse
        '{1'b0, 4'hF,  1, 3'b010, 10'h0FF, 10'h300, 4'hF},   // warm edge
        '{1'b0, 4'hF,  1, 3'b000, 10'h0FF, 10'h300, 4'hF},
        '{1'b0, 4'hF,  6, 3'b010, 10'h111, 10'h222, 4'hF},   // dropped warm edge
        '{1'b0, 4'hF, 10, 3'b100, 10'h111, 10'h222, 4'hF},   // debug edge
        '{1'b0, 4'hF,  2, 3'b000, 10'h111, 10'h222, 4'hF},
        '{1'b0, 4'hF, 30, 3'b100, 10'h0A5, 10'h15A, 4'hF},   // dropped debug edge
        '{1'b0, 4'hF, 10, 3'b000, 10'h0A5, 10'h15A, 4'hF},
        '{1'b0, 4'h5, 12, 3'b000, 10'h1E1, 10'h2D2, 4'h5},   // keys 3 and 1
        '{1'b0, 4'h5,  4, 3'b000, 10'h3FF, 10'h3FF, 4'h5},   // hps forces led 0
        '{1'b1, 4'hF, 16, 3'b000, 10'h001, 10'h200, 4'h5},
        '{1'b0, 4'hF, 12, 3'b000, 10'h200, 10'h000, 4'hF}    // all released
    };

    logic                       fpga_clk_50 = 1'b0;
    logic                       hps_fpga_reset_n;
    logic [key_width-1:0]       key;
    logic [sw_width-1:0]        sw;
    logic [led_width-1:0]       led_ctrl;
    logic [reset_req_width-1:0] reset_req;
    logic [led_width-1:0]       ledr;
    logic [key_width-1:0]       keys_debounced;
    logic [hw_event_width-1:0]  hw_events;
    logic                       cold_reset;
    logic                       warm_reset;
    logic                       debug_reset;
    logic [reset_req_width-1:0] pulses;

    int    seed        = 98368;
    int    cycle_no    = 0;      // edges since reset release
    int    last_toggle = -1;     // cycle of last heartbeat flip
    int    toggle_count = 0;
    bit    led0_prev   = 1'b0;
    bit    ctrl0_prev  = 1'b0;
    int    pulse_left  [reset_req_width] = '{default: 0};   // expected cycles left
    int    pulse_count [reset_req_width] = '{default: 0};   // pulses seen
    bit    pulse_prev  [reset_req_width] = '{default: 1'b0};
    bit    req_seen    [reset_req_width] = '{default: 1'b0};
    bit    edge_d1     [reset_req_width] = '{default: 1'b0};
    bit    edge_d2     [reset_req_width] = '{default: 1'b0};
    string pulse_name  [reset_req_width] = '{"cold_reset", "warm_reset", "debug_reset"};

    assign pulses = {debug_reset, warm_reset, cold_reset};

    fabric_control #(
        .debounce_len (debounce_len),
        .blink_half   (blink_half)
    ) i_fabric_control (
        .fpga_clk_50      (fpga_clk_50),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .key              (key),
        .sw               (sw),
        .led_ctrl         (led_ctrl),
        .reset_req        (reset_req),
        .ledr             (ledr),
        .keys_debounced   (keys_debounced),
        .hw_events        (hw_events),
        .cold_reset       (cold_reset),
        .warm_reset       (warm_reset),
        .debug_reset      (debug_reset)
    );

    always #5 fpga_clk_50 = ~fpga_clk_50;   // 50 MHz stand-in, 10 ns

    task automatic report_failure();
        $display("test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want)
        else
        begin
            $display("Error: %s is %h, expected %h at cycle %0d", name, got, want, cycle_no);
            report_failure();
        end
    endtask

    function automatic int total_hold();
        int sum;
        sum = 0;
        foreach (steps[i])
            sum += steps[i].hold;
        return sum;
    endfunction

    // =========================================================================
    // reference models, stepped once per clock edge
    // =========================================================================
    task automatic step_models();
        bit edge_now;
        for (int b = 0; b < reset_req_width; b++)
        begin
            edge_now = reset_req[b] && !req_seen[b];   // first sampled high here
            if (edge_d2[b] && pulse_left[b] == 0)
                pulse_left[b] = pulse_len[b];          // second edge after sampling
            else if (pulse_left[b] > 0)
                pulse_left[b]--;
            edge_d2[b]  = edge_d1[b];
            edge_d1[b]  = edge_now;
            req_seen[b] = reset_req[b];
        end
    endtask

    task automatic check_outputs();
        bit hb;
        hb = ((cycle_no / blink_half) % 2) == 1;   // flips every blink_half edges
        check_value("ledr[9:1]", 32'(ledr[led_width-1:1]), 32'(led_ctrl[led_width-1:1]));
        check_value("ledr[0]", 32'(ledr[0]), 32'(hb | led_ctrl[0]));
        for (int b = 0; b < reset_req_width; b++)
        begin
            check_value(pulse_name[b], 32'(pulses[b]), 32'(pulse_left[b] > 0));
            if (pulses[b] && !pulse_prev[b])
                pulse_count[b]++;
            pulse_prev[b] = pulses[b];
        end
        // toggle spacing only while the hps leaves led 0 low
        if (!led_ctrl[0] && !ctrl0_prev && ledr[0] != led0_prev)
        begin
            if (last_toggle >= 0)
                check_value("heartbeat gap", 32'(cycle_no - last_toggle), 32'(blink_half));
            last_toggle = cycle_no;
            toggle_count++;
        end
        if (led_ctrl[0])
            last_toggle = -1;
        led0_prev  = ledr[0];
        ctrl0_prev = led_ctrl[0];
    endtask

    task automatic check_keys(input step_t s);
        check_value("keys_debounced", 32'(keys_debounced), 32'(s.exp_keys));
        check_value("hw_events", 32'(hw_events),
                    32'({sw, led_ctrl[led_event_width-1:0], s.exp_keys}));
    endtask

    task automatic run_cycle();
        @(posedge fpga_clk_50);
        #1;                      // outputs settled, inputs change here
        cycle_no++;
        step_models();
        check_outputs();
    endtask

    // =========================================================================
    // stimulus
    // =========================================================================
    initial
    begin : stimulus
        int seg_left;
        bit seg_glitch;
        hps_fpga_reset_n = 1'b0;
        key              = '1;
        sw               = '0;
        led_ctrl         = '0;
        reset_req        = '0;
        repeat (reset_cycles) @(posedge fpga_clk_50);
        #1;
        hps_fpga_reset_n = 1'b1;
        check_value("keys_debounced", 32'(keys_debounced), 32'hF);   // all released
        check_value("ledr[0]", 32'(ledr[0]), 32'h0);
        check_value("reset pulses", 32'(pulses), 32'h0);
        foreach (steps[r])
        begin
            sw         = steps[r].sw;
            led_ctrl   = steps[r].led;
            reset_req  = steps[r].req;
            key        = steps[r].key;
            seg_left   = 0;
            seg_glitch = 1'b0;
            for (int c = 0; c < steps[r].hold; c++)
            begin
                if (steps[r].bounce)
                begin
                    if (seg_left == 0)
                    begin
                        seg_glitch = !seg_glitch;
                        seg_left   = 1 + int'($unsigned($random(seed)) % (debounce_len / 2));
                    end
                    seg_left--;
                    // runs stay under debounce_len, last cycle settles
                    key = (seg_glitch && c != steps[r].hold - 1) ? steps[r].key
                                                                 : steps[r].exp_keys;
                end
                run_cycle();
                if (steps[r].bounce)
                    check_keys(steps[r]);   // must never move
            end
            if (!steps[r].bounce)
                check_keys(steps[r]);
        end
        for (int b = 0; b < reset_req_width; b++)
            check_value({pulse_name[b], " pulses"}, 32'(pulse_count[b]), 32'd1);
        assert (toggle_count >= 3)
        else
        begin
            $display("heartbeat on ledr[0] toggled only %0d times", toggle_count);
            report_failure();
        end
        $display("test passed");
        $finish;
    end

    initial
    begin : watchdog
        int limit_cycles;
        limit_cycles = reset_cycles + total_hold() + margin_cycles;
        repeat (limit_cycles) @(posedge fpga_clk_50);
        $display("timeout: the tests did not finish within %0d cycles", limit_cycles);
        report_failure();
    end

endmodule

// ==== fabric_control.f ====
fabric_pkg.sv
key_debounce.sv
reset_pulse_gen.sv
heartbeat_blinker.sv
fabric_control.sv
fabric_control_assertions.sv
tb_fabric_control.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the fabric_control testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_fabric_control \
    -f fabric_control.f \
    -o tb_fabric_control

# the log decides the result, the exit status of the run does not
./obj_dir/tb_fabric_control | tee sim.log

if grep -qx "test passed" sim.log
then
    echo "simulation PASSED"
    exit 0
else
    echo "simulation FAILED"
    exit 1
fi
